//--- source/neo_io_pkg.sv
package neo_io_pkg;

	// data table and save ram address widths
	localparam int datatable_addr_w = 10;
	localparam int memcard_addr_w = 16;
	localparam int restart_hold_w = 26;

	// core status offsets, low 16 bits of the F0xx_xxxx window
	localparam logic [15:0] reg_core_reset = 16'h0100;
	localparam logic [15:0] reg_dipsw = 16'h0104;
	localparam logic [15:0] reg_system_type = 16'h0108;
	localparam logic [15:0] reg_memcard_en = 16'h010C;
	localparam logic [15:0] reg_overclock = 16'h0110;
	localparam logic [15:0] reg_video_mode = 16'h0200;
	localparam logic [15:0] reg_screen_x = 16'h0204;
	localparam logic [15:0] reg_screen_y = 16'h0208;
	localparam logic [15:0] reg_video_ratio = 16'h020C;
	localparam logic [15:0] reg_ch_enable = 16'h0300;
	localparam logic [15:0] reg_snd_enable = 16'h0304;
	localparam logic [15:0] reg_c1_wait = 16'h0400;
	localparam logic [15:0] reg_pchip_main = 16'h0404;
	localparam logic [15:0] reg_pchip_sub = 16'h0408;
	localparam logic [15:0] reg_cmc = 16'h040C;
	localparam logic [15:0] reg_cart_chip = 16'h0410;

	// data slot ids and the save sizes patched into the table
	localparam logic [31:0] memcard_slot_id = 32'h0000_0101;
	localparam logic [31:0] backup_slot_id = 32'h0000_0102;
	localparam logic [31:0] memcard_size = 32'd8192;
	localparam logic [31:0] backup_size = 32'd65536;

	typedef enum logic [3:0] {
		region_unmapped,
		region_memcard,
		region_backup,
		region_rom_p,
		region_rom_m,
		region_rom_s,
		region_rom_v1,
		region_rom_c,
		region_core_status,
		region_host
	} bridge_region_e;

	typedef enum logic [1:0] {
		scan_addr,
		scan_wait,
		scan_check,
		scan_patch
	} scan_state_e;

	typedef struct packed {
		logic           wr;
		logic           rd;
		logic [31:0]    addr;
		logic [31:0]    wr_data;
		bridge_region_e region;
	} bridge_access_t;

	typedef struct packed {
		logic [7:0]  dipsw;
		logic        system_type;
		logic [1:0]  memory_card_enable;
		logic        cpu_overclock;
		logic        video_mode;
		logic [31:0] screen_x_pos;
		logic [31:0] screen_y_pos;
		logic [2:0]  video_ratio;
		logic [5:0]  ch_enable;
		logic [3:0]  snd_enable;
		logic        use_pcm;
		logic [2:0]  c1_wait;
		logic [3:0]  cart_pchip;
		logic        ms5p_bank;
		logic        xram;
		logic [1:0]  cart_chip;
		logic [1:0]  cmc_chip;
	} settings_t;

	typedef struct packed {
		logic [23:0] p2;
		logic [18:0] m;
		logic [18:0] s;
		logic [23:0] v1;
		logic [25:0] c;
	} rom_masks_t;

endpackage

//--- source/bridge_decode.sv
`timescale 1ns/1ps

module bridge_decode
	import neo_io_pkg::*;
(
	input  logic                      clk_74a,
	input  logic                      reset_l_main,
	input  logic                      bridge_wr,
	input  logic                      bridge_rd,
	input  logic [31:0]               bridge_addr,
	input  logic [31:0]               bridge_wr_data,
	input  logic [31:0]               host_rd_data,
	input  logic [31:0]               status_q,
	input  logic [31:0]               memcard_din,
	input  logic [31:0]               backup_din,
	output bridge_access_t            access,
	output logic [31:0]               bridge_rd_data,
	output logic                      memcard_wr,
	output logic [memcard_addr_w-1:0] memcard_addr,
	output logic [31:0]               memcard_dout,
	output logic                      backup_wr,
	output logic [memcard_addr_w-1:0] backup_addr,
	output logic [31:0]               backup_dout
);

	bridge_region_e region;
	logic [31:0]    memcard_rd_q;
	logic [31:0]    backup_rd_q;

	// narrow windows first, the rom windows sit inside regions 1, 2 and 4
	always_comb begin
		if (bridge_addr[31:28] == 4'h6)
			region = region_memcard;
		else if (bridge_addr[31:28] == 4'h7)
			region = region_backup;
		else if ({bridge_addr[31:19], 3'b000} == 16'h10F8)
			region = region_rom_m;
		else if (bridge_addr[31:20] == 12'h10C)
			region = region_rom_s;
		else if (bridge_addr[31:24] == 8'h10 && !bridge_addr[23])
			region = region_rom_p;
		else if (bridge_addr[31:24] == 8'h20)
			region = region_rom_v1;
		else if (bridge_addr[31:28] == 4'h4)
			region = region_rom_c;
		else if (bridge_addr[31:24] == 8'hF0)
			region = region_core_status;
		else if (bridge_addr[31:28] >= 4'h1 && bridge_addr[31:28] <= 4'h5)
			region = region_unmapped;
		else
			region = region_host;
	end

	assign access = '{
		wr:      bridge_wr,
		rd:      bridge_rd,
		addr:    bridge_addr,
		wr_data: bridge_wr_data,
		region:  region
	};

	// save ram read data is sampled on the strobe, host holds the address
	always_ff @(posedge clk_74a) begin
		if (bridge_rd) begin
			memcard_rd_q <= memcard_din;
			backup_rd_q <= backup_din;
		end
	end

	always_comb begin
		case (access.region)
			region_memcard:     bridge_rd_data = memcard_rd_q;
			region_backup:      bridge_rd_data = backup_rd_q;
			region_core_status: bridge_rd_data = status_q;
			default:            bridge_rd_data = host_rd_data;
		endcase
	end

	assign memcard_wr = access.wr && access.region == region_memcard;
	assign memcard_addr = access.addr[memcard_addr_w-1:0];
	assign memcard_dout = access.wr_data;
	assign backup_wr = access.wr && access.region == region_backup;
	assign backup_addr = access.addr[memcard_addr_w-1:0];
	assign backup_dout = access.wr_data;

	// the bridge issues one transfer at a time
	a_rd_wr_exclusive: assert property (
		@(posedge clk_74a) disable iff (!reset_l_main)
		!(bridge_wr && bridge_rd)
	);

endmodule

//--- source/settings_regs.sv
`timescale 1ns/1ps

module settings_regs
	import neo_io_pkg::*;
(
	input  logic           clk_74a,
	input  logic           reset_l_main,
	input  bridge_access_t access,
	output settings_t      settings,
	output logic [31:0]    status_q,
	output logic           restart_req
);

	logic        pchip_main;
	logic [2:0]  pchip_sub;
	logic        cfg_wr;
	logic        cfg_rd;
	logic [15:0] offset;
	logic [31:0] wdata;
	logic [31:0] rd_val;

	// protection chip select, main chip overrides the sub variants
	function automatic logic [3:0] pchip_encode(input logic main, input logic [2:0] sub);
		if (main)
			return 4'd2;
		if (sub >= 3'd1 && sub <= 3'd5)
			return {1'b0, sub} + 4'd2;
		return 4'd0;
	endfunction

	assign cfg_wr = access.wr && access.region == region_core_status;
	assign cfg_rd = access.rd && access.region == region_core_status;
	assign offset = access.addr[15:0];
	assign wdata = access.wr_data;

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			settings <= '0;
			settings.dipsw <= 8'hFF;
			settings.system_type <= 1'b1;
			settings.ch_enable <= 6'h3F;
			settings.snd_enable <= 4'hF;
			pchip_main <= 1'b0;
			pchip_sub <= 3'd0;
			restart_req <= 1'b0;
		end else begin
			// system type and overclock changes also restart the core
			restart_req <= cfg_wr && ((offset == reg_core_reset && wdata[0]) ||
				offset == reg_system_type || offset == reg_overclock);
			if (cfg_wr) begin
				case (offset)
					reg_dipsw:       settings.dipsw <= wdata[7:0];
					reg_system_type: settings.system_type <= wdata[0];
					reg_memcard_en:  settings.memory_card_enable <= wdata[1:0];
					reg_overclock:   settings.cpu_overclock <= wdata[0];
					reg_video_mode:  settings.video_mode <= wdata[0];
					reg_screen_x:    settings.screen_x_pos <= wdata;
					reg_screen_y:    settings.screen_y_pos <= wdata;
					reg_video_ratio: settings.video_ratio <= wdata[2:0];
					reg_ch_enable:   settings.ch_enable <= wdata[5:0];
					reg_snd_enable:  settings.snd_enable <= wdata[3:0];
					reg_c1_wait:     settings.c1_wait <= wdata[2:0];
					reg_cmc:         settings.cmc_chip <= wdata[1:0];
					reg_cart_chip:   settings.cart_chip <= wdata[1:0];
					reg_pchip_main: begin
						pchip_main <= wdata[0];
						settings.cart_pchip <= pchip_encode(wdata[0], pchip_sub);
					end
					reg_pchip_sub: begin
						pchip_sub <= wdata[2:0];
						settings.cart_pchip <= pchip_encode(pchip_main, wdata[2:0]);
					end
					default: ;
				endcase
			end
		end
	end

	// readback, the restart register itself reads as zero
	always_comb begin
		rd_val = '0;
		case (offset)
			reg_dipsw:       rd_val = {24'd0, settings.dipsw};
			reg_system_type: rd_val = {31'd0, settings.system_type};
			reg_memcard_en:  rd_val = {30'd0, settings.memory_card_enable};
			reg_overclock:   rd_val = {31'd0, settings.cpu_overclock};
			reg_video_mode:  rd_val = {31'd0, settings.video_mode};
			reg_screen_x:    rd_val = settings.screen_x_pos;
			reg_screen_y:    rd_val = settings.screen_y_pos;
			reg_video_ratio: rd_val = {29'd0, settings.video_ratio};
			reg_ch_enable:   rd_val = {26'd0, settings.ch_enable};
			reg_snd_enable:  rd_val = {28'd0, settings.snd_enable};
			reg_c1_wait:     rd_val = {29'd0, settings.c1_wait};
			reg_pchip_main:  rd_val = {31'd0, pchip_main};
			reg_pchip_sub:   rd_val = {29'd0, pchip_sub};
			reg_cmc:         rd_val = {30'd0, settings.cmc_chip};
			reg_cart_chip:   rd_val = {30'd0, settings.cart_chip};
			default:         rd_val = '0;
		endcase
	end

	always_ff @(posedge clk_74a) begin
		if (cfg_rd)
			status_q <= rd_val;
	end

endmodule

//--- source/rom_mask_tracker.sv
`timescale 1ns/1ps

module rom_mask_tracker
	import neo_io_pkg::*;
(
	input  logic           clk_74a,
	input  logic           reset_l_main,
	input  bridge_access_t access,
	output rom_masks_t     masks
);

	logic           wr_q;
	logic [25:0]    addr_q;
	bridge_region_e region_q;
	logic           prom1_access;
	logic [22:0]    fill_p;
	logic [18:0]    fill_ms;
	logic [23:0]    fill_v1;
	logic [9:0]     fill_c;

	// every bit at and below the highest set bit
	function automatic logic [25:0] therm_fill(input logic [25:0] a);
		logic [25:0] f;
		f[25] = a[25];
		for (int i = 24; i >= 0; i--)
			f[i] = f[i + 1] | a[i];
		return f;
	endfunction

	assign fill_p = 23'(therm_fill(26'(addr_q[22:0])));
	assign fill_ms = 19'(therm_fill(26'(addr_q[18:0])));
	assign fill_v1 = 24'(therm_fill(26'(addr_q[23:0])));
	assign fill_c = 10'(therm_fill(26'(addr_q[25:16])));

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			wr_q <= 1'b0;
			prom1_access <= 1'b0;
		end else begin
			wr_q <= access.wr;
			// second p rom bank lives at 0x108x_xxxx
			if (access.wr && access.addr[31:20] == 12'h108)
				prom1_access <= 1'b1;
			else if (access.wr && access.region == region_rom_p)
				prom1_access <= 1'b0;
		end
	end

	always_ff @(posedge clk_74a) begin
		if (access.wr) begin
			addr_q <= access.addr[25:0];
			region_q <= access.region;
		end
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			masks <= '0;
		end else begin
			masks.p2[23] <= prom1_access;
			if (wr_q) begin
				case (region_q)
					region_rom_p:  masks.p2[22:0] <= fill_p;
					region_rom_m:  masks.m <= fill_ms;
					region_rom_s:  masks.s <= fill_ms;
					region_rom_v1: masks.v1 <= fill_v1;
					// c rom is always at least 64k deep
					region_rom_c:  masks.c <= {fill_c, 16'hFFFF};
					default: ;
				endcase
			end
		end
	end

endmodule

//--- source/save_slot_patcher.sv
`timescale 1ns/1ps

module save_slot_patcher
	import neo_io_pkg::*;
(
	input  logic                        clk_74a,
	input  logic                        reset_l_main,
	input  logic [31:0]                 datatable_q,
	output logic [datatable_addr_w-1:0] datatable_addr,
	output logic                        datatable_wren,
	output logic [31:0]                 datatable_data
);

	localparam logic [datatable_addr_w-2:0] last_pair = 63;

	scan_state_e                 state;
	logic [datatable_addr_w-2:0] pair;
	logic [datatable_addr_w-2:0] next_pair;
	logic                        id_match;

	// table entries come in pairs, id at the even word and size at the odd one
	assign pair = datatable_addr[datatable_addr_w-1:1];
	assign next_pair = (pair == last_pair) ? '0 : pair + 1'b1;
	assign id_match = datatable_q == memcard_slot_id || datatable_q == backup_slot_id;

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			state <= scan_addr;
			datatable_addr <= '0;
			datatable_wren <= 1'b0;
		end else begin
			datatable_wren <= 1'b0;
			case (state)
				scan_addr:
					state <= scan_wait;
				// table read data lags the address by a cycle
				scan_wait:
					state <= scan_check;
				scan_check: begin
					if (id_match) begin
						datatable_addr <= {pair, 1'b1};
						datatable_wren <= 1'b1;
						state <= scan_patch;
					end else begin
						datatable_addr <= {next_pair, 1'b0};
						state <= scan_addr;
					end
				end
				scan_patch: begin
					datatable_addr <= {next_pair, 1'b0};
					state <= scan_addr;
				end
			endcase
		end
	end

	always_ff @(posedge clk_74a) begin
		if (state == scan_check)
			datatable_data <= (datatable_q == memcard_slot_id) ? memcard_size : backup_size;
	end

	// size words only, never the id words
	a_wren_odd: assert property (
		@(posedge clk_74a) disable iff (!reset_l_main)
		datatable_wren |-> datatable_addr[0]
	);

endmodule

//--- source/core_start_control.sv
`timescale 1ns/1ps

module core_start_control
	import neo_io_pkg::*;
#(
	parameter logic [restart_hold_w-1:0] restart_hold_cycles = '1
)
(
	input  logic clk_74a,
	input  logic reset_l_main,
	input  logic restart_req,
	input  logic dataslot_allcomplete,
	input  logic core_running,
	output logic start_system
);

	logic [restart_hold_w-1:0] hold_count;

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			hold_count <= '0;
			start_system <= 1'b0;
		end else begin
			if (restart_req)
				hold_count <= restart_hold_cycles;
			else if (hold_count != '0)
				hold_count <= hold_count - 1'b1;
			// drop at once on a restart, the count only loads this edge
			start_system <= !restart_req && hold_count == '0 &&
				dataslot_allcomplete && core_running;
		end
	end

	a_start_after_hold: assert property (
		@(posedge clk_74a) disable iff (!reset_l_main)
		start_system |-> hold_count == '0
	);

endmodule

//--- source/neo_io_top.sv
`timescale 1ns/1ps

module neo_io_top
	import neo_io_pkg::*;
#(
	parameter logic [restart_hold_w-1:0] restart_hold_cycles = '1
)
(
	input  logic                        clk_74a,
	input  logic                        reset_l_main,

	// host bridge
	input  logic                        bridge_wr,
	input  logic                        bridge_rd,
	input  logic [31:0]                 bridge_addr,
	input  logic [31:0]                 bridge_wr_data,
	input  logic [31:0]                 host_rd_data,
	output logic [31:0]                 bridge_rd_data,

	// host status
	input  logic                        core_running,
	input  logic                        dataslot_allcomplete,

	// core configuration
	output settings_t                   settings,
	output rom_masks_t                  rom_masks,
	output logic                        start_system,

	// host data slot table
	output logic [datatable_addr_w-1:0] datatable_addr,
	output logic                        datatable_wren,
	output logic [31:0]                 datatable_data,
	input  logic [31:0]                 datatable_q,

	// memory card and backup ram windows
	output logic                        memcard_wr,
	output logic [memcard_addr_w-1:0]   memcard_addr,
	output logic [31:0]                 memcard_dout,
	input  logic [31:0]                 memcard_din,
	output logic                        backup_wr,
	output logic [memcard_addr_w-1:0]   backup_addr,
	output logic [31:0]                 backup_dout,
	input  logic [31:0]                 backup_din
);

	bridge_access_t access;
	logic [31:0]    status_q;
	logic           restart_req;

	bridge_decode u_bridge_decode (
		.clk_74a        (clk_74a),
		.reset_l_main   (reset_l_main),
		.bridge_wr      (bridge_wr),
		.bridge_rd      (bridge_rd),
		.bridge_addr    (bridge_addr),
		.bridge_wr_data (bridge_wr_data),
		.host_rd_data   (host_rd_data),
		.status_q       (status_q),
		.memcard_din    (memcard_din),
		.backup_din     (backup_din),
		.access         (access),
		.bridge_rd_data (bridge_rd_data),
		.memcard_wr     (memcard_wr),
		.memcard_addr   (memcard_addr),
		.memcard_dout   (memcard_dout),
		.backup_wr      (backup_wr),
		.backup_addr    (backup_addr),
		.backup_dout    (backup_dout)
	);

	settings_regs u_settings_regs (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.access       (access),
		.settings     (settings),
		.status_q     (status_q),
		.restart_req  (restart_req)
	);

	rom_mask_tracker u_rom_mask_tracker (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.access       (access),
		.masks        (rom_masks)
	);

	save_slot_patcher u_save_slot_patcher (
		.clk_74a        (clk_74a),
		.reset_l_main   (reset_l_main),
		.datatable_q    (datatable_q),
		.datatable_addr (datatable_addr),
		.datatable_wren (datatable_wren),
		.datatable_data (datatable_data)
	);

	core_start_control #(
		.restart_hold_cycles (restart_hold_cycles)
	) u_core_start_control (
		.clk_74a              (clk_74a),
		.reset_l_main         (reset_l_main),
		.restart_req          (restart_req),
		.dataslot_allcomplete (dataslot_allcomplete),
		.core_running         (core_running),
		.start_system         (start_system)
	);

endmodule

//--- test/tb_neo_io.sv
`timescale 1ns/1ps

module tb_neo_io
	import neo_io_pkg::*;
();

	localparam int memcard_entry = 10;
	localparam int backup_entry = 80;
	localparam int settings_cycles = 17 * 2 * 8 + 12 * 8;
	localparam int restart_cycles = 4 * 40 + 40;
	localparam int mask_cycles = 2 * 6 * 8;
	localparam int passthru_cycles = 12 * 8;
	localparam int scan_cycles = 64 * 4 + 10;
	localparam int test_cycles = settings_cycles + restart_cycles + mask_cycles +
		passthru_cycles + 2 * scan_cycles + 10;
	localparam int watchdog_cycles = 3 * test_cycles;

	logic        clk_74a = 1'b0;
	logic        reset_l_main;
	logic        bridge_wr;
	logic        bridge_rd;
	logic [31:0] bridge_addr;
	logic [31:0] bridge_wr_data;
	logic [31:0] host_rd_data;
	logic [31:0] bridge_rd_data;
	logic        core_running;
	logic        dataslot_allcomplete;
	settings_t   settings;
	rom_masks_t  rom_masks;
	logic        start_system;
	logic [9:0]  datatable_addr;
	logic        datatable_wren;
	logic [31:0] datatable_data;
	logic [31:0] datatable_q;
	logic        memcard_wr;
	logic [15:0] memcard_addr;
	logic [31:0] memcard_dout;
	logic [31:0] memcard_din;
	logic        backup_wr;
	logic [15:0] backup_addr;
	logic [31:0] backup_dout;
	logic [31:0] backup_din;

	// reference model state
	settings_t   exp_settings;
	logic        exp_pchip_main;
	logic [2:0]  exp_pchip_sub;
	rom_masks_t  exp_masks;
	logic        chk_rd;
	logic [31:0] exp_rd;
	logic        restart_wr;
	int          restart_age = 1000;
	int          value_errors = 0;
	int          other_errors = 0;
	logic [31:0] table_mem [0:1023];
	logic [31:0] table_init [0:1023];
	logic [9:0]  table_rd_addr;
	logic        memcard_patched = 1'b0;
	logic        backup_patched = 1'b0;
	logic [15:0] setting_offsets [0:16] = '{reg_core_reset, reg_dipsw, reg_system_type,
		reg_memcard_en, reg_overclock, reg_video_mode, reg_screen_x, reg_screen_y,
		reg_video_ratio, reg_ch_enable, reg_snd_enable, reg_c1_wait, reg_pchip_main,
		reg_pchip_sub, reg_cmc, reg_cart_chip, 16'h0500};

	neo_io_top #(
		.restart_hold_cycles (26'd16)
	) dut (
		.clk_74a              (clk_74a),
		.reset_l_main         (reset_l_main),
		.bridge_wr            (bridge_wr),
		.bridge_rd            (bridge_rd),
		.bridge_addr          (bridge_addr),
		.bridge_wr_data       (bridge_wr_data),
		.host_rd_data         (host_rd_data),
		.bridge_rd_data       (bridge_rd_data),
		.core_running         (core_running),
		.dataslot_allcomplete (dataslot_allcomplete),
		.settings             (settings),
		.rom_masks            (rom_masks),
		.start_system         (start_system),
		.datatable_addr       (datatable_addr),
		.datatable_wren       (datatable_wren),
		.datatable_data       (datatable_data),
		.datatable_q          (datatable_q),
		.memcard_wr           (memcard_wr),
		.memcard_addr         (memcard_addr),
		.memcard_dout         (memcard_dout),
		.memcard_din          (memcard_din),
		.backup_wr            (backup_wr),
		.backup_addr          (backup_addr),
		.backup_dout          (backup_dout),
		.backup_din           (backup_din)
	);

	always #10 clk_74a = ~clk_74a;

	// host data table with read data one cycle behind the address
	always @(posedge clk_74a) begin
		table_rd_addr = datatable_addr;
		if (datatable_wren) begin
			table_mem[datatable_addr] = datatable_data;
			if (datatable_addr == memcard_entry + 1)
				memcard_patched = 1'b1;
			if (datatable_addr == backup_entry + 1)
				backup_patched = 1'b1;
		end
		#2;
		datatable_q = table_mem[table_rd_addr];
	end

	// cycles since the last write that restarts the core
	always @(posedge clk_74a) begin
		if (restart_wr)
			restart_age <= 0;
		else if (restart_age < 1000)
			restart_age <= restart_age + 1;
	end

	function automatic logic [3:0] expected_pchip(input logic main, input logic [2:0] sub);
		if (main)
			return 4'd2;
		case (sub)
			3'd1: return 4'd3;
			3'd2: return 4'd4;
			3'd3: return 4'd5;
			3'd4: return 4'd6;
			3'd5: return 4'd7;
			default: return 4'd0;
		endcase
	endfunction

	function automatic logic [31:0] expected_readback(input logic [15:0] off);
		case (off)
			reg_dipsw:       return {24'd0, exp_settings.dipsw};
			reg_system_type: return {31'd0, exp_settings.system_type};
			reg_memcard_en:  return {30'd0, exp_settings.memory_card_enable};
			reg_overclock:   return {31'd0, exp_settings.cpu_overclock};
			reg_video_mode:  return {31'd0, exp_settings.video_mode};
			reg_screen_x:    return exp_settings.screen_x_pos;
			reg_screen_y:    return exp_settings.screen_y_pos;
			reg_video_ratio: return {29'd0, exp_settings.video_ratio};
			reg_ch_enable:   return {26'd0, exp_settings.ch_enable};
			reg_snd_enable:  return {28'd0, exp_settings.snd_enable};
			reg_c1_wait:     return {29'd0, exp_settings.c1_wait};
			reg_pchip_main:  return {31'd0, exp_pchip_main};
			reg_pchip_sub:   return {29'd0, exp_pchip_sub};
			reg_cmc:         return {30'd0, exp_settings.cmc_chip};
			reg_cart_chip:   return {30'd0, exp_settings.cart_chip};
			default:         return 32'd0;
		endcase
	endfunction

	// all bits from the highest set bit down
	function automatic logic [25:0] fill_below(input logic [25:0] v);
		logic [25:0] r;
		r = '0;
		for (int i = 0; i < 26; i++)
			if (v[i])
				r = 26'((64'd1 << (i + 1)) - 64'd1);
		return r;
	endfunction

	function automatic logic [31:0] random_span();
		return $urandom >> $urandom_range(31, 0);
	endfunction

	task automatic apply_settings_model(input logic [31:0] addr, input logic [31:0] data);
		if (addr[31:24] != 8'hF0)
			return;
		case (addr[15:0])
			reg_dipsw:       exp_settings.dipsw = data[7:0];
			reg_system_type: exp_settings.system_type = data[0];
			reg_memcard_en:  exp_settings.memory_card_enable = data[1:0];
			reg_overclock:   exp_settings.cpu_overclock = data[0];
			reg_video_mode:  exp_settings.video_mode = data[0];
			reg_screen_x:    exp_settings.screen_x_pos = data;
			reg_screen_y:    exp_settings.screen_y_pos = data;
			reg_video_ratio: exp_settings.video_ratio = data[2:0];
			reg_ch_enable:   exp_settings.ch_enable = data[5:0];
			reg_snd_enable:  exp_settings.snd_enable = data[3:0];
			reg_c1_wait:     exp_settings.c1_wait = data[2:0];
			reg_cmc:         exp_settings.cmc_chip = data[1:0];
			reg_cart_chip:   exp_settings.cart_chip = data[1:0];
			reg_pchip_main:  exp_pchip_main = data[0];
			reg_pchip_sub:   exp_pchip_sub = data[2:0];
			default: ;
		endcase
		exp_settings.cart_pchip = expected_pchip(exp_pchip_main, exp_pchip_sub);
	endtask

	task automatic apply_mask_model(input logic [31:0] addr);
		if (addr[31:20] == 12'h108)
			exp_masks.p2[23] = 1'b1;
		if (addr[31:16] >= 16'h10F8 && addr[31:16] <= 16'h10FF) begin
			exp_masks.m = 19'(fill_below(26'(addr[18:0])));
		end else if (addr[31:20] == 12'h10C) begin
			exp_masks.s = 19'(fill_below(26'(addr[18:0])));
		end else if (addr[31:24] == 8'h10 && !addr[23]) begin
			exp_masks.p2 = {1'b0, 23'(fill_below(26'(addr[22:0])))};
		end else if (addr[31:24] == 8'h20) begin
			exp_masks.v1 = 24'(fill_below(26'(addr[23:0])));
		end else if (addr[31:28] == 4'h4) begin
			exp_masks.c = {10'(fill_below(26'(addr[25:16]))), 16'hFFFF};
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_74a);
		#2;
		bridge_wr = 1'b1;
		bridge_addr = addr;
		bridge_wr_data = data;
		restart_wr = addr[31:24] == 8'hF0 && ((addr[15:0] == reg_core_reset && data[0]) ||
			addr[15:0] == reg_system_type || addr[15:0] == reg_overclock);
		@(posedge clk_74a);
		#2;
		bridge_wr = 1'b0;
		restart_wr = 1'b0;
		apply_settings_model(addr, data);
		@(posedge clk_74a);
		#2;
		apply_mask_model(addr);
	endtask

	// address stays on the bus while the read value is checked
	task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected,
		input logic scramble_din);
		@(posedge clk_74a);
		#2;
		bridge_rd = 1'b1;
		bridge_addr = addr;
		@(posedge clk_74a);
		#2;
		bridge_rd = 1'b0;
		if (scramble_din) begin
			memcard_din = ~memcard_din;
			backup_din = ~backup_din;
		end
		exp_rd = expected;
		chk_rd = 1'b1;
		@(posedge clk_74a);
		#2;
		chk_rd = 1'b0;
	endtask

	task automatic wait_for_start(input int max_cycles);
		int n;
		n = 0;
		while (!start_system && n < max_cycles) begin
			@(posedge clk_74a);
			n++;
		end
		if (!start_system) begin
			other_errors++;
			$display("start_system did not rise within %0d cycles", max_cycles);
		end
		@(posedge clk_74a);
		#2;
	endtask

	task automatic check_table();
		logic [31:0] expected;
		for (int i = 0; i < 1024; i++) begin
			expected = table_init[i];
			if (i == memcard_entry + 1)
				expected = 32'd8192;
			if (i == backup_entry + 1)
				expected = 32'd65536;
			assert (table_mem[i] == expected) else begin
				value_errors++;
				$display("ERR table_mem[%0d] got %h exp %h", i, table_mem[i], expected);
			end
		end
	endtask

	a_settings: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		settings == exp_settings) else begin
		value_errors++;
		$display("ERR settings got %h exp %h", $sampled(settings), $sampled(exp_settings));
	end

	a_masks: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		rom_masks == exp_masks) else begin
		value_errors++;
		$display("ERR rom_masks got %h exp %h", $sampled(rom_masks), $sampled(exp_masks));
	end

	a_readback: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		chk_rd |-> bridge_rd_data == exp_rd) else begin
		value_errors++;
		$display("ERR bridge_rd_data got %h exp %h", $sampled(bridge_rd_data),
			$sampled(exp_rd));
	end

	a_restart_hold: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		(restart_age >= 2 && restart_age <= 16) |-> !start_system) else begin
		value_errors++;
		$display("ERR start_system got %h exp %h", $sampled(start_system), 1'b0);
	end

	a_start_cond: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		start_system |-> $past(dataslot_allcomplete && core_running)) else begin
		other_errors++;
		$display("start_system rose while the host was not ready");
	end

	a_memcard_port: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		memcard_wr == (bridge_wr && bridge_addr[31:28] == 4'h6) && (!memcard_wr ||
		(memcard_addr == bridge_addr[15:0] && memcard_dout == bridge_wr_data))) else begin
		value_errors++;
		$display("ERR memcard port wr %h addr %h dout %h exp addr %h dout %h",
			$sampled(memcard_wr), $sampled(memcard_addr), $sampled(memcard_dout),
			$sampled(bridge_addr[15:0]), $sampled(bridge_wr_data));
	end

	a_backup_port: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		backup_wr == (bridge_wr && bridge_addr[31:28] == 4'h7) && (!backup_wr ||
		(backup_addr == bridge_addr[15:0] && backup_dout == bridge_wr_data))) else begin
		value_errors++;
		$display("ERR backup port wr %h addr %h dout %h exp addr %h dout %h",
			$sampled(backup_wr), $sampled(backup_addr), $sampled(backup_dout),
			$sampled(bridge_addr[15:0]), $sampled(bridge_wr_data));
	end

	a_table_write: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		datatable_wren |->
		(datatable_addr == memcard_entry + 1 && datatable_data == 32'd8192) ||
		(datatable_addr == backup_entry + 1 && datatable_data == 32'd65536)) else begin
		value_errors++;
		$display("ERR datatable write addr %h data %h", $sampled(datatable_addr),
			$sampled(datatable_data));
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_74a);
		$display("watchdog expired after %0d cycles", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		logic [31:0] id;
		void'($urandom(86798));
		for (int i = 0; i < 1024; i++) begin
			id = $urandom;
			if (i % 2 == 0 && (id == memcard_slot_id || id == backup_slot_id))
				id = id + 32'h100;
			table_mem[i] = id;
		end
		table_mem[memcard_entry] = memcard_slot_id;
		table_mem[backup_entry] = backup_slot_id;
		for (int i = 0; i < 1024; i++)
			table_init[i] = table_mem[i];
		reset_l_main = 1'b0;
		bridge_wr = 1'b0;
		bridge_rd = 1'b0;
		bridge_addr = '0;
		bridge_wr_data = '0;
		host_rd_data = '0;
		core_running = 1'b1;
		dataslot_allcomplete = 1'b1;
		memcard_din = '0;
		backup_din = '0;
		datatable_q = '0;
		chk_rd = 1'b0;
		exp_rd = '0;
		restart_wr = 1'b0;
		exp_settings = '0;
		exp_settings.dipsw = 8'hFF;
		exp_settings.system_type = 1'b1;
		exp_settings.ch_enable = 6'h3F;
		exp_settings.snd_enable = 4'hF;
		exp_pchip_main = 1'b0;
		exp_pchip_sub = 3'd0;
		exp_masks = '0;
		repeat (5) @(posedge clk_74a);
		#2;
		reset_l_main = 1'b1;

		// settings write and readback
		for (int round = 0; round < 2; round++)
			for (int i = 0; i < 17; i++) begin
				bus_write({16'hF000, setting_offsets[i]}, $urandom);
				bus_read({16'hF000, setting_offsets[i]},
					expected_readback(setting_offsets[i]), 1'b0);
			end
		bus_write({16'hF000, reg_pchip_main}, 32'd0);
		for (int s = 0; s < 8; s++) begin
			bus_write({16'hF000, reg_pchip_sub}, s);
			bus_read({16'hF000, reg_pchip_sub}, expected_readback(reg_pchip_sub), 1'b0);
		end
		bus_write({16'hF000, reg_pchip_main}, 32'd1);
		bus_write({16'hF000, reg_pchip_main}, 32'd0);

		// restart hold and host ready gating
		wait_for_start(40);
		bus_write({16'hF000, reg_system_type}, $urandom);
		wait_for_start(40);
		core_running = 1'b0;
		bus_write({16'hF000, reg_overclock}, $urandom);
		repeat (30) @(posedge clk_74a);
		#2;
		core_running = 1'b1;
		wait_for_start(5);
		bus_write({16'hF000, reg_core_reset}, 32'd1);
		wait_for_start(40);
		dataslot_allcomplete = 1'b0;
		repeat (3) @(posedge clk_74a);
		#2;
		dataslot_allcomplete = 1'b1;
		wait_for_start(5);

		// rom window masks
		for (int round = 0; round < 2; round++) begin
			bus_write(32'h1080_0000 | (random_span() & 32'h000F_FFFF), $urandom);
			bus_write(32'h1000_0000 | (random_span() & 32'h007F_FFFF), $urandom);
			bus_write(32'h10F8_0000 | (random_span() & 32'h0007_FFFF), $urandom);
			bus_write(32'h10C0_0000 | (random_span() & 32'h000F_FFFF), $urandom);
			bus_write(32'h2000_0000 | (random_span() & 32'h00FF_FFFF), $urandom);
			bus_write(32'h4000_0000 | (random_span() & 32'h0FFF_FFFF), $urandom);
		end

		// memcard, backup and host pass-through
		for (int i = 0; i < 2; i++) begin
			bus_write(32'h6000_0000 | ($urandom & 32'h0FFF_FFFF), $urandom);
			bus_write(32'h7000_0000 | ($urandom & 32'h0FFF_FFFF), $urandom);
			memcard_din = $urandom;
			bus_read(32'h6000_0000 | ($urandom & 32'h0000_FFFF), memcard_din, 1'b1);
			backup_din = $urandom;
			bus_read(32'h7000_0000 | ($urandom & 32'h0000_FFFF), backup_din, 1'b1);
			host_rd_data = $urandom;
			bus_read(32'h8000_0000 | ($urandom & 32'h0FFF_FFFF), host_rd_data, 1'b0);
			bus_read(32'h3000_0000 | ($urandom & 32'h0FFF_FFFF), host_rd_data, 1'b0);
		end

		// save-slot patching over at least one full scan
		for (int n = 0; n < scan_cycles && !(memcard_patched && backup_patched); n++)
			@(posedge clk_74a);
		if (!(memcard_patched && backup_patched)) begin
			other_errors++;
			$display("save slot sizes were not patched within %0d cycles", scan_cycles);
		end
		repeat (scan_cycles) @(posedge clk_74a);
		#2;
		check_table();

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- filelist.f
source/neo_io_pkg.sv
source/bridge_decode.sv
source/settings_regs.sv
source/rom_mask_tracker.sv
source/save_slot_patcher.sv
source/core_start_control.sv
source/neo_io_top.sv
test/tb_neo_io.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing
TOP       = tb_neo_io
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
